// File: project.f
+incdir+common
common/cpu_pkg.sv
common/bp_pkg.sv
common/resolve_if.sv
branch_predictor/pred_table.sv
branch_predictor/branch_predictor.sv
verilog/fetch_pc.sv
verilog/fetch_top.sv
tb/fetch_chk.sv
tb/fetch_monitor.sv
tb/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_next_pc

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - common/bp_pkg.sv
      - common/resolve_if.sv
      - branch_predictor/pred_table.sv
      - branch_predictor/branch_predictor.sv
      - verilog/fetch_pc.sv
      - verilog/fetch_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/fetch_chk.sv
      - tb/fetch_monitor.sv
      - tb/fetch_tb.sv

// File: tb/fetch_tb.sv
`include "fetch_params.svh"

module fetch_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int SEQ_CYCLES = 20;
	localparam int STALL_TEST_CYCLES = 16;
	localparam int LEARN_TEST_CYCLES = 40;
	localparam int HYST_TEST_CYCLES = 50;
	localparam int RAND_CYCLES = 400;
	localparam int MARGIN_CYCLES = 100;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + SEQ_CYCLES + STALL_TEST_CYCLES
		+ LEARN_TEST_CYCLES + HYST_TEST_CYCLES + RAND_CYCLES + MARGIN_CYCLES;

	logic clk = 1'b0;
	logic reset_n;
	logic stall;
	logic resolve_valid;
	cpu_pkg::word_t resolve_pc;
	cpu_pkg::word_t resolve_next_pc;
	logic resolve_is_branch;
	logic resolve_flush;
	cpu_pkg::word_t fetch_pc;
	logic pred_taken;
	int pass_tests;
	int fail_tests;
	logic [15:0] lfsr_state = 16'd46365;

	always #(CLK_PERIOD / 2) clk = ~clk;

	fetch_top uut (
		.clk(clk),
		.reset_n(reset_n),
		.stall(stall),
		.resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc),
		.resolve_next_pc(resolve_next_pc),
		.resolve_is_branch(resolve_is_branch),
		.resolve_flush(resolve_flush),
		.fetch_pc(fetch_pc),
		.pred_taken(pred_taken)
	);

	fetch_monitor mon (
		.clk(clk),
		.reset_n(reset_n),
		.stall(stall),
		.resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc),
		.resolve_next_pc(resolve_next_pc),
		.resolve_is_branch(resolve_is_branch),
		.resolve_flush(resolve_flush),
		.fetch_pc(fetch_pc),
		.pred_taken(pred_taken),
		.pass_tests(pass_tests),
		.fail_tests(fail_tests)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task draw_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[14:0], lfsr_state[0]};
		end
	endtask

	task set_inputs(input logic v, input cpu_pkg::word_t pc, input cpu_pkg::word_t npc,
			input logic br, input logic fl, input logic st);
		resolve_valid = v;
		resolve_pc = pc;
		resolve_next_pc = npc;
		resolve_is_branch = br;
		resolve_flush = fl;
		stall = st;
	endtask

	// One cycle of stimulus, applied at the falling edge
	task drive_cycle(input logic v, input cpu_pkg::word_t pc, input cpu_pkg::word_t npc,
			input logic br, input logic fl, input logic st);
		@(negedge clk);
		set_inputs(v, pc, npc, br, fl, st);
	endtask

	task idle(input int n, input logic st);
		repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, st);
	endtask

	task wait_pc(input cpu_pkg::word_t target, input int max_cycles);
		int n;
		n = 0;
		while (fetch_pc !== target && n < max_cycles) begin
			idle(1, 1'b0);
			n++;
		end
		if (fetch_pc !== target)
			mon.note_failure($sformatf("fetch_pc never reached %h", target));
	endtask

	task random_mix(input int cycles);
		logic [15:0] v;
		logic [15:0] fl;
		logic [15:0] st;
		logic [15:0] br;
		logic [15:0] tk;
		logic [15:0] pc_bits;
		logic [15:0] tgt_bits;
		cpu_pkg::word_t pc;
		cpu_pkg::word_t npc;
		for (int i = 0; i < cycles; i++) begin
			draw_bits(1, v);
			draw_bits(2, fl);
			draw_bits(2, st);
			draw_bits(1, br);
			draw_bits(1, tk);
			draw_bits(4, pc_bits);
			draw_bits(4, tgt_bits);
			pc = {10'd0, pc_bits[3:2], 2'b00, pc_bits[1:0]}; // 4 indices, 4 tags
			npc = tk[0] ? {10'd0, tgt_bits[3:2], 2'b00, tgt_bits[1:0]} : pc + 16'd1;
			drive_cycle(v[0], pc, npc, br[0], fl[1:0] == 2'b00, st[1:0] == 2'b00);
		end
	endtask

	initial begin
		reset_n = 1'b0;
		set_inputs(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
		idle(RESET_CYCLES, 1'b0);
		reset_n = 1'b1;

		idle(SEQ_CYCLES, 1'b0);
		mon.end_test("reset_and_sequence", 1'b0);

		idle(5, 1'b1);
		drive_cycle(1'b1, 16'h0040, 16'h0100, 1'b0, 1'b1, 1'b1); // Flush while stalled
		idle(4, 1'b1);
		idle(6, 1'b0);
		mon.end_test("stall_and_redirect", 1'b0);

		drive_cycle(1'b1, 16'h0000, 16'h0100, 1'b0, 1'b1, 1'b0);
		drive_cycle(1'b1, 16'h010c, 16'h0103, 1'b1, 1'b0, 1'b0); // Taken branch at 0x010c
		wait_pc(16'h010c, 32);
		idle(2, 1'b0);
		mon.end_test("learning", 1'b1);

		drive_cycle(1'b1, 16'h010c, 16'h0103, 1'b1, 1'b0, 1'b0); // Up to strong taken
		idle(2, 1'b0);
		drive_cycle(1'b1, 16'h0000, 16'h0208, 1'b0, 1'b1, 1'b0);
		wait_pc(16'h020d, 16); // Same index, other tag
		drive_cycle(1'b1, 16'h010c, 16'h010d, 1'b1, 1'b0, 1'b0);
		drive_cycle(1'b1, 16'h010c, 16'h010d, 1'b1, 1'b0, 1'b0);
		drive_cycle(1'b1, 16'h0000, 16'h0108, 1'b0, 1'b1, 1'b0);
		wait_pc(16'h010d, 16); // Falls through once the counter drops
		idle(4, 1'b0);
		mon.end_test("hysteresis_and_aliasing", 1'b0);

		random_mix(RAND_CYCLES);
		idle(2, 1'b0);
		mon.end_test("random_mix", 1'b0);

		$display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
			pass_tests, fail_tests, uut.u_chk.fail_count);
		if (fail_tests == 0 && uut.u_chk.fail_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: tb/fetch_monitor.sv
`include "fetch_params.svh"

// Reference model of the next-PC logic, compared against the DUT every cycle
module fetch_monitor (
	input logic clk,
	input logic reset_n,
	input logic stall,
	input logic resolve_valid,
	input cpu_pkg::word_t resolve_pc,
	input cpu_pkg::word_t resolve_next_pc,
	input logic resolve_is_branch,
	input logic resolve_flush,
	input cpu_pkg::word_t fetch_pc,
	input logic pred_taken,
	output int pass_tests,
	output int fail_tests
);

	localparam int ENTRIES = 1 << `IDX_SIZE;

	cpu_pkg::word_t m_pc;
	logic m_valid [ENTRIES];
	cpu_pkg::tag_t m_tag [ENTRIES];
	cpu_pkg::word_t m_target [ENTRIES];
	int m_ctr [ENTRIES];
	int test_errs = 0;
	int hits_seen = 0;

	initial begin
		pass_tests = 0;
		fail_tests = 0;
	end

	always @(posedge clk) begin : model_step
		int idx;
		int r_idx;
		logic exp_taken;
		logic br_taken;
		cpu_pkg::word_t exp_next;
		if (!reset_n) begin
			m_pc = `RESET_PC;
			for (int i = 0; i < ENTRIES; i++) begin
				m_valid[i] = 1'b0;
				m_ctr[i] = 1; // Weak not taken
			end
		end else begin
			idx = m_pc[`IDX_SIZE-1:0];
			exp_taken = m_valid[idx] && (m_tag[idx] == m_pc[`WORD_SIZE-1:`IDX_SIZE])
				&& (m_ctr[idx] >= 2);
			exp_next = exp_taken ? m_target[idx] : cpu_pkg::word_t'(m_pc + 16'd1);
			if (fetch_pc !== m_pc) begin
				$display("ERR t=%0t fetch_pc expected %h got %h", $time, m_pc, fetch_pc);
				test_errs++;
			end
			if (pred_taken !== exp_taken) begin
				$display("ERR t=%0t pred_taken expected %b got %b", $time, exp_taken, pred_taken);
				test_errs++;
			end
			if (pred_taken === 1'b1)
				hits_seen++;
			// Training from the resolve report
			if (resolve_valid && resolve_is_branch) begin
				r_idx = resolve_pc[`IDX_SIZE-1:0];
				br_taken = (resolve_next_pc != cpu_pkg::word_t'(resolve_pc + 16'd1));
				if (br_taken) begin
					if (m_ctr[r_idx] < 3)
						m_ctr[r_idx]++;
					m_valid[r_idx] = 1'b1;
					m_tag[r_idx] = resolve_pc[`WORD_SIZE-1:`IDX_SIZE];
					m_target[r_idx] = resolve_next_pc;
				end else if (m_ctr[r_idx] > 0) begin
					m_ctr[r_idx]--;
				end
			end
			if (resolve_valid && resolve_flush)
				m_pc = resolve_next_pc;
			else if (!stall)
				m_pc = exp_next;
		end
	end

	task note_failure(input string msg);
		$display("t=%0t %s", $time, msg);
		test_errs++;
	endtask

	// One line per finished test, need_hit demands at least one taken prediction
	task end_test(input string name, input bit need_hit);
		if (need_hit && hits_seen == 0)
			note_failure({name, ": the predictor never predicted a taken branch"});
		if (test_errs == 0) begin
			pass_tests++;
			$display("test %s: ok", name);
		end else begin
			fail_tests++;
			$display("test %s: %0d errors", name, test_errs);
		end
		test_errs = 0;
		hits_seen = 0;
	endtask

endmodule

// File: tb/fetch_chk.sv
`include "fetch_params.svh"

// Protocol properties of the fetch PC, bound into fetch_top
module fetch_chk (
	input logic clk,
	input logic reset_n,
	input logic stall,
	input logic resolve_valid,
	input logic resolve_flush,
	input cpu_pkg::word_t resolve_next_pc,
	input cpu_pkg::word_t fetch_pc
);

	int fail_count = 0; // Failed assertions so far

	// A flush lands on the very next edge, stall or not
	a_redirect: assert property (@(posedge clk) disable iff (!reset_n)
		(resolve_valid && resolve_flush) |=> (fetch_pc == $past(resolve_next_pc)))
		else begin
			fail_count++;
			$error("fetch_pc did not take the flush target");
		end

	a_stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
		(stall && !(resolve_valid && resolve_flush)) |=> (fetch_pc == $past(fetch_pc)))
		else begin
			fail_count++;
			$error("fetch_pc moved while stalled");
		end

	// First cycle out of reset
	a_reset_pc: assert property (@(posedge clk) $rose(reset_n) |-> (fetch_pc == `RESET_PC))
		else begin
			fail_count++;
			$error("fetch_pc is not the reset PC after reset");
		end

endmodule

bind fetch_top fetch_chk u_chk (
	.clk(clk),
	.reset_n(reset_n),
	.stall(stall),
	.resolve_valid(resolve_valid),
	.resolve_flush(resolve_flush),
	.resolve_next_pc(resolve_next_pc),
	.fetch_pc(fetch_pc)
);

// File: verilog/fetch_top.sv
`include "fetch_params.svh"

// Next-PC subsystem of the fetch stage
module fetch_top (
	input logic clk,
	input logic reset_n,
	input logic stall,

	// Resolve report from the back end
	input logic resolve_valid,
	input cpu_pkg::word_t resolve_pc,
	input cpu_pkg::word_t resolve_next_pc,
	input logic resolve_is_branch,
	input logic resolve_flush,

	output cpu_pkg::word_t fetch_pc,
	output logic pred_taken
);

	cpu_pkg::word_t pred_next_pc;

	resolve_if u_res ();

	// Source side of the report bundle
	assign u_res.valid = resolve_valid;
	assign u_res.pc = resolve_pc;
	assign u_res.next_pc = resolve_next_pc;
	assign u_res.is_branch = resolve_is_branch;
	assign u_res.flush = resolve_flush;

	branch_predictor u_bp (
		.clk(clk),
		.reset_n(reset_n),
		.pc(fetch_pc),
		.res(u_res.pred),
		.pred_next_pc(pred_next_pc),
		.pred_taken(pred_taken)
	);

	fetch_pc u_pc (
		.clk(clk),
		.reset_n(reset_n),
		.stall(stall),
		.pred_next_pc(pred_next_pc),
		.res(u_res.redirect),
		.pc(fetch_pc)
	);

endmodule

// File: verilog/fetch_pc.sv
`include "fetch_params.svh"

// Fetch PC register
// Priority is flush redirect, then stall, then the predicted next PC
module fetch_pc (
	input logic clk,
	input logic reset_n,
	input logic stall,
	input cpu_pkg::word_t pred_next_pc,
	resolve_if.redirect res,
	output cpu_pkg::word_t pc
);

	logic redirect;

	// A flush wins even while the front end is stalled
	assign redirect = res.valid && res.flush;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= `RESET_PC;
		end else if (redirect) begin
			pc <= res.next_pc; // Mispredict recovery
		end else if (!stall) begin
			pc <= pred_next_pc;
		end
	end

endmodule

// File: branch_predictor/branch_predictor.sv
`include "fetch_params.svh"

// BTB plus 2-bit counters, combinational lookup on the fetch PC
module branch_predictor (
	input logic clk,
	input logic reset_n,
	input cpu_pkg::word_t pc,
	resolve_if.pred res,
	output cpu_pkg::word_t pred_next_pc,
	output logic pred_taken
);

	// Lookup side
	cpu_pkg::tag_t fetch_tag;
	cpu_pkg::idx_t fetch_idx;
	bp_pkg::btb_entry_t btb_rd;
	bp_pkg::ctr_t ctr_rd;
	logic btb_hit;
	logic ctr_dir;

	// Training side
	cpu_pkg::tag_t res_tag;
	cpu_pkg::idx_t res_idx;
	cpu_pkg::word_t res_seq_pc;
	logic res_taken;
	logic train;
	bp_pkg::btb_entry_t btb_old;
	bp_pkg::btb_entry_t btb_wr;
	logic btb_wr_en;
	bp_pkg::ctr_t ctr_old;
	bp_pkg::ctr_t ctr_new;

	assign fetch_tag = pc[`WORD_SIZE-1:`IDX_SIZE];
	assign fetch_idx = pc[`IDX_SIZE-1:0];

	assign btb_hit = btb_rd.valid && (btb_rd.tag == fetch_tag);
	assign ctr_dir = (ctr_rd >= bp_pkg::CTR_WT); // Weak or strong taken

	assign pred_taken = btb_hit && ctr_dir;
	assign pred_next_pc = pred_taken ? btb_rd.target : pc + 1'b1; // Wraps at 16 bits

	assign res_tag = res.pc[`WORD_SIZE-1:`IDX_SIZE];
	assign res_idx = res.pc[`IDX_SIZE-1:0];
	assign res_seq_pc = res.pc + 1'b1;
	assign res_taken = (res.next_pc != res_seq_pc); // Anything but fall-through
	assign train = res.valid && res.is_branch;

	// Saturating step toward the actual outcome
	always_comb begin
		ctr_new = ctr_old;
		if (res_taken) begin
			if (ctr_old != bp_pkg::CTR_ST)
				ctr_new = ctr_old + 2'd1;
		end else begin
			if (ctr_old != bp_pkg::CTR_SNT)
				ctr_new = ctr_old - 2'd1;
		end
	end

	always_comb begin
		btb_wr.valid = 1'b1;
		btb_wr.tag = res_tag;
		btb_wr.target = res.next_pc;
	end

	// Only taken branches claim a slot, rewrites of an identical entry are skipped
	assign btb_wr_en = train && res_taken && (btb_old != btb_wr);

	pred_table #(
		.entry_t(bp_pkg::btb_entry_t),
		.DEPTH_LOG2(`IDX_SIZE),
		.RESET_VALUE(bp_pkg::BTB_RESET)
	) u_btb (
		.clk(clk),
		.reset_n(reset_n),
		.rd_idx(fetch_idx),
		.rd_data(btb_rd),
		.upd_idx(res_idx),
		.upd_data(btb_old),
		.wr_en(btb_wr_en),
		.wr_idx(res_idx),
		.wr_data(btb_wr)
	);

	pred_table #(
		.entry_t(bp_pkg::ctr_t),
		.DEPTH_LOG2(`IDX_SIZE),
		.RESET_VALUE(bp_pkg::CTR_RESET)
	) u_ctr (
		.clk(clk),
		.reset_n(reset_n),
		.rd_idx(fetch_idx),
		.rd_data(ctr_rd),
		.upd_idx(res_idx),
		.upd_data(ctr_old),
		.wr_en(train),       // Every resolved branch moves its counter
		.wr_idx(res_idx),
		.wr_data(ctr_new)
	);

endmodule

// File: branch_predictor/pred_table.sv
`include "fetch_params.svh"

// Direct-mapped table shared by the BTB and the direction counters
module pred_table #(
	parameter type entry_t = logic,
	parameter int DEPTH_LOG2 = `IDX_SIZE,
	parameter entry_t RESET_VALUE = '0
) (
	input logic clk,
	input logic reset_n,

	// Lookup port, follows the fetch PC
	input cpu_pkg::idx_t rd_idx,
	output entry_t rd_data,

	// Second read port for read-modify-write on training
	input cpu_pkg::idx_t upd_idx,
	output entry_t upd_data,

	// Training write, lands on the rising edge
	input logic wr_en,
	input cpu_pkg::idx_t wr_idx,
	input entry_t wr_data
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	entry_t mem [DEPTH];

	// Reads see the old contents during a write cycle
	assign rd_data = mem[rd_idx];
	assign upd_data = mem[upd_idx];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= RESET_VALUE; // Whole table back to a known state
			end
		end else if (wr_en) begin
			mem[wr_idx] <= wr_data;
		end
	end

endmodule

// File: common/resolve_if.sv
`include "fetch_params.svh"

// One resolved-instruction report from the back end, single-cycle strobe
interface resolve_if;

	logic valid;              // Report strobe, no back-pressure
	cpu_pkg::word_t pc;       // PC of the resolved instruction
	cpu_pkg::word_t next_pc;  // Where execution really continues
	logic is_branch;          // Branch or jump
	logic flush;              // Front end must redirect to next_pc

	// Driven by the top level from the back-end strobe
	modport src (
		output valid,
		output pc,
		output next_pc,
		output is_branch,
		output flush
	);

	// Predictor only trains, it never redirects
	modport pred (
		input valid,
		input pc,
		input next_pc,
		input is_branch
	);

	// PC register only cares about flushes
	modport redirect (
		input valid,
		input next_pc,
		input flush
	);

endinterface

// File: common/bp_pkg.sv
`include "fetch_params.svh"

package bp_pkg;

	// One BTB slot, valid bit on top
	typedef struct packed {
		logic valid;
		cpu_pkg::tag_t tag;   // Upper bits of the branch PC
		cpu_pkg::word_t target; // Where the branch went last time it was taken
	} btb_entry_t;

	// 2-bit saturating direction counter
	typedef logic [1:0] ctr_t;

	localparam ctr_t CTR_SNT = 2'd0; // Strong not taken
	localparam ctr_t CTR_WNT = 2'd1; // Weak not taken
	localparam ctr_t CTR_WT = 2'd2;  // Weak taken
	localparam ctr_t CTR_ST = 2'd3;  // Strong taken

	// Counters start one step away from predicting taken
	localparam ctr_t CTR_RESET = CTR_WNT;

	// Empty slot, never hits
	localparam btb_entry_t BTB_RESET = '0;

endpackage

// File: common/cpu_pkg.sv
`include "fetch_params.svh"

package cpu_pkg;

	// Instruction word and PC
	typedef logic [`WORD_SIZE-1:0] word_t;

	// Upper PC bits stored in the BTB for hit detection
	typedef logic [`TAG_SIZE-1:0] tag_t;

	// Low PC bits selecting a table entry
	typedef logic [`IDX_SIZE-1:0] idx_t;

endpackage

// File: common/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Datapath word, also the PC width
`define WORD_SIZE 16

// Low PC bits that index the predictor tables
`define IDX_SIZE 4

// Remaining upper PC bits kept as the BTB tag
`define TAG_SIZE (`WORD_SIZE - `IDX_SIZE)

// First fetch address out of reset
`define RESET_PC 16'h0000

`endif
